// File: src/ahbPkg.sv
`default_nettype none

package ahbPkg;

    ////////////////////////////////////////////////////////////
    // bus widths and fixed values
    ////////////////////////////////////////////////////////////
    localparam int dataW = 32;                          // HWDATA / HRDATA width
    localparam int addrW = 32;                          // HADDR width
    localparam logic [dataW-1:0] badData = 32'hdeadbeef; // read value for unmapped space

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam logic [addrW-1:0] ramBase  = 32'h2000_0000; // ram window start
    localparam logic [addrW-1:0] gpioBase = 32'h5000_0000; // gpio window start, 16 bytes

    localparam logic [3:0] gpioOut0Ofs = 4'h0;  // read-write output 0
    localparam logic [3:0] gpioOut1Ofs = 4'h4;  // read-write output 1
    localparam logic [3:0] gpioIn0Ofs  = 4'h8;  // read-only input 0
    localparam logic [3:0] gpioIn1Ofs  = 4'hc;  // read-only input 1

    ////////////////////////////////////////////////////////////
    // transfer encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        transIdle   = 2'b00,
        transBusy   = 2'b01,
        transNonseq = 2'b10,    // bit 1 set marks a real transfer
        transSeq    = 2'b11
    } htransT;

    typedef enum logic [2:0] {
        sizeByte = 3'b000,
        sizeHalf = 3'b001,
        sizeWord = 3'b010       // widest size on this bus
    } hsizeT;

    typedef enum logic [1:0] {
        selNone = 2'd0,         // unmapped, returns badData
        selRam  = 2'd1,
        selGpio = 2'd2
    } slaveSelT;

endpackage

`default_nettype wire

// File: src/ahbDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module ahbDecoder #(
    parameter int ramWords = 1024                       // ram depth in words, power of two
) (
    input  wire logic [ahbPkg::addrW-1:0] HADDR,        // address-phase address
    output logic                          ramSel,       // ram window hit
    output logic                          gpioSel,      // gpio window hit
    output ahbPkg::slaveSelT              addrSel       // encoded select for read mux
);
    import ahbPkg::*;

    localparam int ramAddrBits  = $clog2(ramWords) + 2; // byte offset bits inside ram
    localparam int gpioAddrBits = 4;                    // 16-byte register block

    ////////////////////////////////////////////////////////////
    // window compare
    ////////////////////////////////////////////////////////////
    // both windows are aligned to their own size, so only the
    // bits above the window offset need to match the base
    always_comb begin
        ramSel  = (HADDR[addrW-1:ramAddrBits] == ramBase[addrW-1:ramAddrBits]);
        gpioSel = (HADDR[addrW-1:gpioAddrBits] == gpioBase[addrW-1:gpioAddrBits]);
    end

    ////////////////////////////////////////////////////////////
    // select encoding
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (ramSel) begin
            addrSel = selRam;                           // ram wins if windows ever overlap
        end else if (gpioSel) begin
            addrSel = selGpio;
        end else begin
            addrSel = selNone;                          // anything else is unmapped
        end
    end

endmodule

`default_nettype wire

// File: src/ahbAddrPhase.sv
`timescale 1ns/1ps
`default_nettype none

module ahbAddrPhase #(
    parameter type addrT = logic [3:0]                  // captured low address bits
) (
    input  wire logic                     HCLK,
    input  wire logic                     rstN,
    input  wire logic                     hSel,         // this slave decoded
    input  wire logic [1:0]               HTRANS,
    input  wire logic                     HWRITE,
    input  wire logic [2:0]               HSIZE,
    input  wire logic [ahbPkg::addrW-1:0] HADDR,
    output logic                          phaseValid,   // data phase for this slave
    output logic                          phaseWrite,   // data phase is a write
    output ahbPkg::hsizeT                 phaseSize,    // size of the transfer
    output addrT                          phaseAddr     // low address bits
);
    import ahbPkg::*;

    localparam int addrBits = $bits(addrT);

    logic transValid;                                   // nonseq or seq on the bus
    logic capture;                                      // selected valid address phase

    assign transValid = (HTRANS == transNonseq) || (HTRANS == transSeq);
    assign capture    = hSel && transValid;

    ////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            phaseValid <= 1'b0;
            phaseWrite <= 1'b0;
        end else begin
            phaseValid <= capture;                      // high for exactly one data phase
            phaseWrite <= capture && HWRITE;
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        if (capture) begin
            phaseAddr <= addrT'(HADDR[addrBits-1:0]);   // truncate to slave window
            phaseSize <= hsizeT'(HSIZE);
        end
    end

endmodule

`default_nettype wire

// File: src/ahbRam.sv
`timescale 1ns/1ps
`default_nettype none

module ahbRam #(
    parameter int ramWords = 1024                       // depth in words, power of two
) (
    input  wire logic                     HCLK,
    input  wire logic                     rstN,
    input  wire logic                     ramSel,       // from decoder
    input  wire logic [1:0]               HTRANS,
    input  wire logic                     HWRITE,
    input  wire logic [2:0]               HSIZE,
    input  wire logic [ahbPkg::addrW-1:0] HADDR,
    input  wire logic [ahbPkg::dataW-1:0] HWDATA,       // valid in data phase
    output logic      [ahbPkg::dataW-1:0] ramRdata      // to read mux
);
    import ahbPkg::*;

    localparam int byteAddrW = $clog2(ramWords) + 2;    // byte address inside ram
    localparam int laneCount = dataW / 8;

    typedef logic [byteAddrW-1:0] ramAddrT;

    logic                 phaseValid;
    logic                 phaseWrite;
    hsizeT                phaseSize;
    ramAddrT              phaseAddr;
    logic [laneCount-1:0] laneEn;                       // byte lanes written this cycle
    logic [dataW-1:0]     mem [ramWords];               // word-wide storage

    ahbAddrPhase #(
        .addrT      (ramAddrT)
    ) addrPhase (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .hSel       (ramSel),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSIZE      (HSIZE),
        .HADDR      (HADDR),
        .phaseValid (phaseValid),
        .phaseWrite (phaseWrite),
        .phaseSize  (phaseSize),
        .phaseAddr  (phaseAddr)
    );

    ////////////////////////////////////////////////////////////
    // byte-lane enables
    ////////////////////////////////////////////////////////////
    always_comb begin
        laneEn = '0;
        if (phaseValid && phaseWrite) begin
            case (phaseSize)
                sizeByte: laneEn[phaseAddr[1:0]] = 1'b1;                // one lane
                sizeHalf: laneEn = phaseAddr[1] ? 4'b1100 : 4'b0011;    // upper or lower half
                sizeWord: laneEn = 4'b1111;
                default:  laneEn = '0;                  // wider sizes not supported
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        for (int lane = 0; lane < laneCount; lane++) begin
            if (laneEn[lane]) begin
                mem[phaseAddr[byteAddrW-1:2]][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
            end
        end
    end

    // whole word, lanes picked by the master
    assign ramRdata = mem[phaseAddr[byteAddrW-1:2]];

endmodule

`default_nettype wire

// File: src/ahbGpio.sv
`timescale 1ns/1ps
`default_nettype none

module ahbGpio (
    input  wire logic                     HCLK,
    input  wire logic                     rstN,
    input  wire logic                     gpioSel,      // from decoder
    input  wire logic [1:0]               HTRANS,
    input  wire logic                     HWRITE,
    input  wire logic [2:0]               HSIZE,
    input  wire logic [ahbPkg::addrW-1:0] HADDR,
    input  wire logic [ahbPkg::dataW-1:0] HWDATA,
    output logic      [ahbPkg::dataW-1:0] gpioRdata,    // to read mux
    input  wire logic [15:0]              gpioIn0,      // read-only at offset 8
    input  wire logic [15:0]              gpioIn1,      // read-only at offset c
    output logic      [15:0]              gpioOut0,     // read-write at offset 0
    output logic      [15:0]              gpioOut1      // read-write at offset 4
);
    import ahbPkg::*;

    logic       phaseValid;
    logic       phaseWrite;
    hsizeT      phaseSize;
    logic [3:0] phaseAddr;                              // register offset
    logic       wordWrite;                              // word write in data phase

    ahbAddrPhase #(
        .addrT      (logic [3:0])
    ) addrPhase (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .hSel       (gpioSel),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSIZE      (HSIZE),
        .HADDR      (HADDR),
        .phaseValid (phaseValid),
        .phaseWrite (phaseWrite),
        .phaseSize  (phaseSize),
        .phaseAddr  (phaseAddr)
    );

    assign wordWrite = phaseValid && phaseWrite && (phaseSize == sizeWord);

    ////////////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            gpioOut0 <= '0;
            gpioOut1 <= '0;
        end else if (wordWrite) begin
            if (phaseAddr == gpioOut0Ofs) begin
                gpioOut0 <= HWDATA[15:0];               // low half only
            end
            if (phaseAddr == gpioOut1Ofs) begin
                gpioOut1 <= HWDATA[15:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (phaseAddr)
            gpioOut0Ofs: gpioRdata = dataW'(gpioOut0);
            gpioOut1Ofs: gpioRdata = dataW'(gpioOut1);
            gpioIn0Ofs:  gpioRdata = dataW'(gpioIn0);   // live pins
            gpioIn1Ofs:  gpioRdata = dataW'(gpioIn1);
            default:     gpioRdata = '0;                // unaligned offset
        endcase
    end

endmodule

`default_nettype wire

// File: src/ahbReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module ahbReadMux (
    input  wire logic                     HCLK,
    input  wire logic                     rstN,
    input  wire ahbPkg::slaveSelT         addrSel,      // decoded in address phase
    input  wire logic [1:0]               HTRANS,
    input  wire logic [ahbPkg::dataW-1:0] ramRdata,
    input  wire logic [ahbPkg::dataW-1:0] gpioRdata,
    output logic      [ahbPkg::dataW-1:0] HRDATA        // back to master
);
    import ahbPkg::*;

    logic     transValid;                               // real transfer this cycle
    slaveSelT dataSel;                                  // select held for data phase

    assign transValid = (HTRANS == transNonseq) || (HTRANS == transSeq);

    ////////////////////////////////////////////////////////////
    // data-phase select
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            dataSel <= selNone;
        end else if (transValid) begin
            dataSel <= addrSel;                         // every address phase
        end else begin
            dataSel <= selNone;                         // idle or busy cycle
        end
    end

    ////////////////////////////////////////////////////////////
    // read data multiplexer
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (dataSel)
            selRam:  HRDATA = ramRdata;
            selGpio: HRDATA = gpioRdata;
            default: HRDATA = badData;                  // unmapped or no transfer
        endcase
    end

endmodule

`default_nettype wire

// File: src/ahbSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ahbSubsystem #(
    parameter int ramWords = 1024                       // ram depth in words
) (
    input  wire logic                     HCLK,         // bus clock
    input  wire logic                     rstN,         // bus reset
    // address phase from master
    input  wire logic [ahbPkg::addrW-1:0] HADDR,
    input  wire logic [1:0]               HTRANS,
    input  wire logic                     HWRITE,
    input  wire logic [2:0]               HSIZE,
    // data phase
    input  wire logic [ahbPkg::dataW-1:0] HWDATA,
    output logic      [ahbPkg::dataW-1:0] HRDATA,
    // gpio pins
    input  wire logic [15:0]              gpioIn0,
    input  wire logic [15:0]              gpioIn1,
    output logic      [15:0]              gpioOut0,
    output logic      [15:0]              gpioOut1
);
    import ahbPkg::*;

    logic             ramSel;                           // slave selects
    logic             gpioSel;
    slaveSelT         addrSel;                          // encoded select for mux
    logic [dataW-1:0] ramRdata;                         // slave read data
    logic [dataW-1:0] gpioRdata;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    ahbDecoder #(
        .ramWords   (ramWords)
    ) decoder (
        .HADDR      (HADDR),
        .ramSel     (ramSel),
        .gpioSel    (gpioSel),
        .addrSel    (addrSel)
    );

    ////////////////////////////////////////////////////////////
    // slaves
    ////////////////////////////////////////////////////////////
    ahbRam #(
        .ramWords   (ramWords)
    ) ram (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .ramSel     (ramSel),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSIZE      (HSIZE),
        .HADDR      (HADDR),
        .HWDATA     (HWDATA),
        .ramRdata   (ramRdata)
    );

    ahbGpio gpio (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .gpioSel    (gpioSel),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSIZE      (HSIZE),
        .HADDR      (HADDR),
        .HWDATA     (HWDATA),
        .gpioRdata  (gpioRdata),
        .gpioIn0    (gpioIn0),
        .gpioIn1    (gpioIn1),
        .gpioOut0   (gpioOut0),
        .gpioOut1   (gpioOut1)
    );

    ////////////////////////////////////////////////////////////
    // read return
    ////////////////////////////////////////////////////////////
    ahbReadMux readMux (
        .HCLK       (HCLK),
        .rstN       (rstN),
        .addrSel    (addrSel),
        .HTRANS     (HTRANS),
        .ramRdata   (ramRdata),
        .gpioRdata  (gpioRdata),
        .HRDATA     (HRDATA)
    );

endmodule

`default_nettype wire

// File: include/ahbTbTasks.svh
`ifndef ahbTbTasksSvh
`define ahbTbTasksSvh

////////////////////////////////////////////////////////////
// error handling
////////////////////////////////////////////////////////////
task automatic abortRun();
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
endtask

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        abortRun();
    end
endtask

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////
function automatic slaveSelT regionOf(input logic [31:0] addr);
    if (addr >= ramBase && addr - ramBase < 32'(ramWords * 4)) return selRam;
    if (addr >= gpioBase && addr - gpioBase < 32'h10) return selGpio;
    return selNone;                                     // hole in the map
endfunction

task automatic modelWrite(input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] data);
    int idx;
    int bytes;
    int first;
    idx = int'((addr - ramBase) >> 2);
    bytes = 1 << size;                                  // 1, 2 or 4 bytes
    first = int'(addr[1:0]) & ~(bytes - 1);             // aligned start lane
    case (regionOf(addr))
        selRam: begin
            for (int lane = first; lane < first + bytes; lane++) begin
                ramImage[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
            if (size == sizeWord) begin
                ramKnown[idx] = 1'b1;                   // whole word now defined
            end
        end
        selGpio: begin
            if (size == sizeWord && addr[3:0] == gpioOut0Ofs) outModel0 = data[15:0];
            if (size == sizeWord && addr[3:0] == gpioOut1Ofs) outModel1 = data[15:0];
        end
        default: ;                                      // unmapped write is dropped
    endcase
endtask

// returns 1 when the expected value is fully known
function automatic logic predictRead(input logic valid, input logic [31:0] addr,
                                     output logic [31:0] value);
    int idx;
    idx = int'((addr - ramBase) >> 2);
    value = badData;
    if (!valid) return 1'b1;                            // mux parks on badData
    case (regionOf(addr))
        selRam: begin
            value = ramImage[idx];
            return ramKnown[idx];
        end
        selGpio: begin
            case (addr[3:0])
                gpioOut0Ofs: value = {16'h0, outModel0};
                gpioOut1Ofs: value = {16'h0, outModel1};
                gpioIn0Ofs:  value = {16'h0, gpioIn0};  // live pins
                gpioIn1Ofs:  value = {16'h0, gpioIn1};
                default:     value = 32'h0;
            endcase
            return 1'b1;
        end
        default: return 1'b1;
    endcase
endfunction

////////////////////////////////////////////////////////////
// bus driving, one clock per call
////////////////////////////////////////////////////////////
task automatic busCycle(input logic [1:0] trans, input logic [31:0] addr, input logic write,
                        input logic [2:0] size, input logic [31:0] wdata);
    logic [31:0] expected;
    logic        known;
    @(negedge HCLK);
    checkValue("gpioOut0", 32'(gpioOut0), 32'(outModel0));  // last write already visible
    checkValue("gpioOut1", 32'(gpioOut1), 32'(outModel1));
    if (pendValid && pendWrite) begin
        HWDATA = pendWdata;                             // data phase of pending write
        modelWrite(pendAddr, pendSize, pendWdata);
    end else begin
        known = predictRead(pendValid, pendAddr, expected);
        if (known) checkValue("HRDATA", HRDATA, expected);
        HWDATA = $urandom;                              // junk, must be ignored
    end
    gpioIn0 = 16'($urandom);
    gpioIn1 = 16'($urandom);
    HTRANS = trans;                                     // next address phase
    HADDR = addr;
    HWRITE = write;
    HSIZE = size;
    pendValid = trans[1];
    pendWrite = write;
    pendAddr = addr;
    pendSize = size;
    pendWdata = wdata;
endtask

`endif

// File: verification/ahbSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module ahbSubsystemTb;
    import ahbPkg::*;

    localparam int ramWords = 1024;
    localparam int clockPeriod = 100;                   // ns
    localparam int resetCycles = 10;
    localparam int directedTransfers = 32;              // upper bound of directed part
    localparam int randomTransfers = 2000;
    localparam int transfers = directedTransfers + randomTransfers;
    localparam int timeoutCycles = resetCycles + transfers * 2 + 50;

    logic        HCLK = 1'b0;
    logic        rstN;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    logic [2:0]  HSIZE;
    logic [31:0] HWDATA;
    logic [31:0] HRDATA;
    logic [15:0] gpioIn0;
    logic [15:0] gpioIn1;
    logic [15:0] gpioOut0;
    logic [15:0] gpioOut1;

    logic [31:0] ramImage [ramWords];                   // model ram
    bit          ramKnown [ramWords];                   // word written in full
    logic [15:0] outModel0;
    logic [15:0] outModel1;
    logic        pendValid;                             // transfer in data phase
    logic        pendWrite;
    logic [31:0] pendAddr;
    logic [2:0]  pendSize;
    logic [31:0] pendWdata;

    `include "ahbTbTasks.svh"

    ahbSubsystem #(.ramWords(ramWords)) uut (
        .HCLK(HCLK), .rstN(rstN), .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE),
        .HSIZE(HSIZE), .HWDATA(HWDATA), .HRDATA(HRDATA), .gpioIn0(gpioIn0),
        .gpioIn1(gpioIn1), .gpioOut0(gpioOut0), .gpioOut1(gpioOut1)
    );

    always #(clockPeriod / 2) HCLK = ~HCLK;

    initial begin
        #(timeoutCycles * clockPeriod);
        $display("Timeout: the test sequence did not finish in %0d cycles", timeoutCycles);
        abortRun();
    end

    ////////////////////////////////////////////////////////////
    // random transfer to ram, gpio, a hole, or no transfer
    ////////////////////////////////////////////////////////////
    task automatic randomCycle();
        logic [31:0] addr;
        logic [2:0]  size;
        logic [1:0]  trans;
        int          wordIdx;
        int          kind;
        kind = $urandom_range(0, 9);
        trans = $urandom_range(0, 1) ? transNonseq : transSeq;
        size = sizeWord;
        wordIdx = ($urandom_range(0, 7) == 0) ? ramWords - 1 : $urandom_range(0, 15);
        addr = ramBase + 32'(wordIdx * 4);
        if (kind < 2) begin
            trans = $urandom_range(0, 1) ? transBusy : transIdle;   // must not write
        end else if (kind < 7) begin
            size = 3'($urandom_range(0, 2));
            addr = addr + (32'($urandom_range(0, 3)) & ~((32'd1 << size) - 1));
        end else if (kind < 9) begin
            addr = gpioBase + 32'($urandom_range(0, 3) * 4);
        end else begin
            case ($urandom_range(0, 2))
                0: addr = ramBase + 32'(ramWords * 4) + 32'($urandom_range(0, 63) * 4);
                1: addr = gpioBase + 32'h10 + 32'($urandom_range(0, 15) * 4);
                default: addr = $urandom & 32'h0fff_fffc;           // nothing mapped low
            endcase
        end
        busCycle(trans, addr, 1'($urandom_range(0, 1)), size, $urandom);
    endtask

    initial begin
        rstN = 1'b0;
        HADDR = '0;
        HTRANS = transIdle;
        HWRITE = 1'b0;
        HSIZE = sizeWord;
        HWDATA = '0;
        gpioIn0 = '0;
        gpioIn1 = '0;
        outModel0 = '0;
        outModel1 = '0;
        pendValid = 1'b0;
        pendWrite = 1'b0;
        pendAddr = '0;
        pendSize = sizeWord;
        pendWdata = '0;
        void'($urandom(32'hd052_e56c));
        repeat (resetCycles) @(negedge HCLK);
        rstN = 1'b1;
        checkValue("HRDATA", HRDATA, badData);          // select parked after reset
        checkValue("gpioOut0", 32'(gpioOut0), 32'h0);
        checkValue("gpioOut1", 32'(gpioOut1), 32'h0);

        ////////////////////////////////////////////////////////////
        // directed part
        ////////////////////////////////////////////////////////////
        busCycle(transNonseq, 32'h3000_0010, 1'b0, sizeWord, 32'h0);   // first phase unmapped
        for (int i = 0; i < 16; i++) begin
            busCycle(transNonseq, ramBase + 32'(i * 4), 1'b1, sizeWord, $urandom);
        end
        busCycle(transNonseq, ramBase + 32'h14, 1'b1, sizeWord, 32'h1234_5678);
        busCycle(transSeq, ramBase + 32'h14, 1'b0, sizeWord, 32'h0);    // back to back
        busCycle(transNonseq, ramBase + 32'h16, 1'b1, sizeHalf, 32'habcd_0000);
        busCycle(transNonseq, ramBase + 32'h15, 1'b1, sizeByte, 32'h0000_5a00);
        busCycle(transNonseq, ramBase + 32'h14, 1'b0, sizeWord, 32'h0);
        busCycle(transNonseq, gpioBase + 32'h0, 1'b1, sizeWord, 32'hffff_1234);
        busCycle(transNonseq, gpioBase + 32'h0, 1'b0, sizeWord, 32'h0);
        busCycle(transNonseq, gpioBase + 32'h8, 1'b1, sizeWord, 32'h5555_5555);
        busCycle(transNonseq, gpioBase + 32'h8, 1'b0, sizeWord, 32'h0);
        busCycle(transNonseq, gpioBase + 32'hc, 1'b0, sizeWord, 32'h0);

        repeat (randomTransfers) randomCycle();
        busCycle(transIdle, 32'h0, 1'b0, sizeWord, 32'h0);  // drain last data phase
        busCycle(transIdle, 32'h0, 1'b0, sizeWord, 32'h0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
src/ahbPkg.sv
src/ahbDecoder.sv
src/ahbAddrPhase.sv
src/ahbRam.sv
src/ahbGpio.sv
src/ahbReadMux.sv
src/ahbSubsystem.sv
verification/ahbSubsystemTb.sv
